//--- hdl/mam_wb_pkg.sv
// Shared types and helpers for the memory access to Wishbone bridge.
// The bridge, the SRAM model and the top level import what they need.

`default_nettype none

package mam_wb_pkg;

   localparam int BEATS_W = 14;  // Burst length counter width

   // Request direction
   typedef enum logic {
      op_read  = 1'b0,
      op_write = 1'b1
   } mam_op_t;

   // Cycle type identifier, registered feedback subset
   typedef enum logic [2:0] {
      cti_classic = 3'b000,
      cti_incr    = 3'b010,
      cti_end     = 3'b111
   } wb_cti_t;

   typedef enum logic [3:0] {
      idle,
      write_last,       // Last write beat on the bus
      write_last_wait,  // Waiting for the last write word
      write,            // Write beat on the bus, more to follow
      write_wait,       // Waiting for the next write word
      read_last,        // Last beat of a single read or one-beat burst
      read_last_burst,  // Last beat of a longer burst
      read_last_wait,   // Last word held for the read stream
      read_start,       // First beat of a burst on the bus
      read,             // Later burst beat on the bus
      read_wait         // Word held, fetching paused
   } wb_if_state_t;

   // One byte select per byte of data
   function automatic int sel_width(input int data_width);
      return data_width / 8;
   endfunction

endpackage

`default_nettype wire

//--- hdl/mam_wb_if.sv
// Wishbone master side of the memory access bridge.
// Accepts one request at a time and runs it as a classic single cycle or as
// an incrementing burst. Write and read words travel on valid/ready streams.
// A read beat is forwarded on its ack when the reader is ready, otherwise
// it is held and the bus is paused until the word is taken.

`timescale 1ns/1ps
`default_nettype none

module mam_wb_if #(
   parameter int DATA_WIDTH = 32,  // 8, 16 or 32
   parameter int ADDR_WIDTH = 32
) (
   input  wire                                           clk_i,
   input  wire                                           rst_i,

   input  wire                                           req_valid_i,  // New request
   output logic                                          req_ready_o,
   input  wire  mam_wb_pkg::mam_op_t                     req_rw_i,
   input  wire  [ADDR_WIDTH-1:0]                         req_addr_i,   // Byte address
   input  wire                                           req_burst_i,  // Incrementing burst
   input  wire  [mam_wb_pkg::BEATS_W-1:0]                req_beats_i,  // Words in the burst

   input  wire                                           write_valid_i,
   input  wire  [DATA_WIDTH-1:0]                         write_data_i,
   input  wire  [mam_wb_pkg::sel_width(DATA_WIDTH)-1:0]  write_strb_i, // Single writes only
   output logic                                          write_ready_o,

   output logic                                          read_valid_o,
   output logic [DATA_WIDTH-1:0]                         read_data_o,
   input  wire                                           read_ready_i,

   output logic                                          stb_o,
   output logic                                          cyc_o,
   output logic                                          we_o,
   output logic [ADDR_WIDTH-1:0]                         addr_o,
   output logic [DATA_WIDTH-1:0]                         dat_o,
   output mam_wb_pkg::wb_cti_t                           cti_o,
   output logic [1:0]                                    bte_o,
   output logic [mam_wb_pkg::sel_width(DATA_WIDTH)-1:0]  sel_o,
   input  wire                                           ack_i,
   input  wire  [DATA_WIDTH-1:0]                         dat_i
);

   import mam_wb_pkg::*;

   localparam int SW = sel_width(DATA_WIDTH);

   wb_if_state_t          state;
   wb_if_state_t          nxt_state;

   logic                  burst_q;        // Current request is a burst
   logic                  nxt_burst;
   logic [BEATS_W-1:0]    beats;          // Beats not yet acked
   logic [BEATS_W-1:0]    nxt_beats;
   logic [DATA_WIDTH-1:0] read_data_q;    // Word held for the read stream
   logic [DATA_WIDTH-1:0] nxt_read_data;
   logic                  nxt_stb;
   logic                  nxt_cyc;
   logic                  nxt_we;
   wb_cti_t               nxt_cti;
   logic [ADDR_WIDTH-1:0] nxt_addr;
   logic [DATA_WIDTH-1:0] nxt_dat;
   logic [SW-1:0]         nxt_sel;
   logic [ADDR_WIDTH-1:0] addr_step;      // Address of the following word
   logic                  req_single;     // Request needs just one beat

   assign addr_step  = addr_o + ADDR_WIDTH'(SW);
   assign req_single = !req_burst_i || (req_beats_i == BEATS_W'(1));
   assign bte_o      = 2'b00;  // Linear bursts only

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state   <= idle;
         stb_o   <= 1'b0;
         cyc_o   <= 1'b0;
         we_o    <= 1'b0;
         cti_o   <= cti_classic;
         burst_q <= 1'b0;
         beats   <= '0;
      end else begin
         state   <= nxt_state;
         stb_o   <= nxt_stb;
         cyc_o   <= nxt_cyc;
         we_o    <= nxt_we;
         cti_o   <= nxt_cti;
         burst_q <= nxt_burst;
         beats   <= nxt_beats;
      end
      addr_o      <= nxt_addr;
      dat_o       <= nxt_dat;
      sel_o       <= nxt_sel;
      read_data_q <= nxt_read_data;
   end

   always_comb begin
      nxt_state     = state;
      nxt_burst     = burst_q;
      nxt_beats     = beats;
      nxt_read_data = read_data_q;
      nxt_stb       = stb_o;
      nxt_cyc       = cyc_o;
      nxt_we        = we_o;
      nxt_cti       = cti_o;
      nxt_addr      = addr_o;
      nxt_dat       = dat_o;
      nxt_sel       = sel_o;

      req_ready_o   = 1'b0;
      write_ready_o = 1'b0;
      read_valid_o  = 1'b0;
      read_data_o   = read_data_q;

      case (state)
         idle: begin
            req_ready_o   = 1'b1;
            write_ready_o = req_valid_i && (req_rw_i == op_write);  // First word rides along
            if (req_valid_i) begin
               nxt_cyc   = 1'b1;
               nxt_we    = (req_rw_i == op_write);
               nxt_addr  = req_addr_i;
               nxt_burst = req_burst_i;
               nxt_beats = req_burst_i ? req_beats_i : BEATS_W'(1);
               nxt_sel   = {SW{1'b1}};
               if (!req_burst_i) begin
                  nxt_cti = cti_classic;
               end else if (req_single) begin
                  nxt_cti = cti_end;  // One-beat burst
               end else begin
                  nxt_cti = cti_incr;
               end
               if (req_rw_i == op_write) begin
                  nxt_stb = write_valid_i;  // Bus waits for the first word
                  if (write_valid_i) begin
                     nxt_dat = write_data_i;
                     if (!req_burst_i) begin
                        nxt_sel = write_strb_i;
                     end
                  end
                  if (req_single) begin
                     if (write_valid_i) begin
                        nxt_state = write_last;
                     end else begin
                        nxt_state = write_last_wait;
                     end
                  end else begin
                     if (write_valid_i) begin
                        nxt_state = write;
                     end else begin
                        nxt_state = write_wait;
                     end
                  end
               end else begin
                  nxt_stb = 1'b1;
                  if (req_single) begin
                     nxt_state = read_last;
                  end else begin
                     nxt_state = read_start;
                  end
               end
            end
         end

         write_last_wait: begin
            write_ready_o = 1'b1;
            if (write_valid_i) begin
               nxt_stb   = 1'b1;
               nxt_dat   = write_data_i;
               nxt_sel   = burst_q ? {SW{1'b1}} : write_strb_i;
               nxt_state = write_last;
            end
         end

         write_last: begin
            if (ack_i) begin
               nxt_stb   = 1'b0;
               nxt_cyc   = 1'b0;
               nxt_cti   = cti_classic;
               nxt_state = idle;
            end
         end

         write_wait: begin
            write_ready_o = 1'b1;
            if (write_valid_i) begin
               nxt_stb   = 1'b1;
               nxt_dat   = write_data_i;
               nxt_state = write;
            end
         end

         write: begin
            if (ack_i) begin
               write_ready_o = 1'b1;  // Next word may follow straight on
               nxt_addr      = addr_step;
               nxt_beats     = beats - 1'b1;
               nxt_stb       = write_valid_i;
               if (write_valid_i) begin
                  nxt_dat = write_data_i;
               end
               if (beats == BEATS_W'(2)) begin
                  nxt_cti = cti_end;
                  if (write_valid_i) begin
                     nxt_state = write_last;
                  end else begin
                     nxt_state = write_last_wait;
                  end
               end else if (write_valid_i) begin
                  nxt_state = write;
               end else begin
                  nxt_state = write_wait;
               end
            end
         end

         read_start, read: begin
            read_valid_o = ack_i;  // Forward on ack
            read_data_o  = dat_i;
            if (ack_i) begin
               nxt_addr  = addr_step;
               nxt_beats = beats - 1'b1;
               if (!read_ready_i) begin
                  nxt_read_data = dat_i;  // Hold it and pause the bus
                  nxt_stb       = 1'b0;
                  nxt_state     = read_wait;
               end else if (beats == BEATS_W'(2)) begin
                  nxt_cti   = cti_end;
                  nxt_state = read_last_burst;
               end else begin
                  nxt_state = read;
               end
            end
         end

         read_wait: begin
            read_valid_o = 1'b1;
            if (read_ready_i) begin
               nxt_stb = 1'b1;  // Resume fetching
               if (beats == BEATS_W'(1)) begin
                  nxt_cti   = cti_end;
                  nxt_state = read_last_burst;
               end else begin
                  nxt_state = read;
               end
            end
         end

         read_last, read_last_burst: begin
            read_valid_o = ack_i;
            read_data_o  = dat_i;
            if (ack_i) begin
               nxt_stb = 1'b0;
               if (read_ready_i) begin
                  nxt_cyc   = 1'b0;
                  nxt_cti   = cti_classic;
                  nxt_state = idle;
               end else begin
                  nxt_read_data = dat_i;
                  nxt_state     = read_last_wait;
               end
            end
         end

         read_last_wait: begin
            read_valid_o = 1'b1;
            if (read_ready_i) begin
               nxt_cyc   = 1'b0;
               nxt_cti   = cti_classic;
               nxt_state = idle;
            end
         end

         default: begin
            nxt_stb   = 1'b0;
            nxt_cyc   = 1'b0;
            nxt_state = idle;
         end
      endcase
   end

   a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_o |-> cyc_o);

   a_burst_len: assert property (@(posedge clk_i) disable iff (rst_i)
      (req_valid_i && req_ready_o && req_burst_i) |-> (req_beats_i != '0));

   // A word offered to the reader stays put until it is taken
   a_read_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (read_valid_o && !read_ready_i) |=> (read_valid_o && $stable(read_data_o)));

endmodule

`default_nettype wire

//--- hdl/wb_sram.sv
// Wishbone slave memory for the bridge.
// Word addressed by the byte address over the byte count, with one select
// per byte lane. Each beat is acked WAIT_STATES+1 cycles after stb and cyc
// are seen; writes land and read data is presented on the ack cycle.

`timescale 1ns/1ps
`default_nettype none

module wb_sram #(
   parameter int DATA_WIDTH  = 32,
   parameter int ADDR_WIDTH  = 32,
   parameter int MEM_WORDS   = 1024,  // Power of two
   parameter int WAIT_STATES = 1
) (
   input  wire                                           clk_i,
   input  wire                                           rst_i,
   input  wire                                           stb_i,
   input  wire                                           cyc_i,
   input  wire                                           we_i,
   input  wire  [ADDR_WIDTH-1:0]                         addr_i,
   input  wire  [DATA_WIDTH-1:0]                         dat_i,
   input  wire  [mam_wb_pkg::sel_width(DATA_WIDTH)-1:0]  sel_i,
   input  wire  [2:0]                                    cti_i,
   input  wire  [1:0]                                    bte_i,
   output logic                                          ack_o,
   output logic [DATA_WIDTH-1:0]                         dat_o
);

   import mam_wb_pkg::*;

   localparam int SW    = sel_width(DATA_WIDTH);
   localparam int OFF_W = $clog2(SW);                  // Byte offset bits
   localparam int IDX_W = $clog2(MEM_WORDS);
   localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

   logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
   logic [CNT_W-1:0]      wait_cnt;
   logic [ADDR_WIDTH-1:0] word_addr;
   logic [IDX_W-1:0]      idx;
   logic                  access;    // Beat requested
   logic                  ack_set;   // Wait states done, ack next cycle

   assign access    = stb_i && cyc_i;
   assign word_addr = addr_i >> OFF_W;
   assign idx       = word_addr[IDX_W-1:0];
   assign ack_set   = access && !ack_o && (wait_cnt == CNT_W'(WAIT_STATES));

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o    <= 1'b0;
         wait_cnt <= '0;
      end else if (!access || ack_o) begin
         ack_o    <= 1'b0;  // Single-cycle ack, then count again
         wait_cnt <= '0;
      end else if (ack_set) begin
         ack_o    <= 1'b1;
         wait_cnt <= '0;
      end else begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (access && ack_o && we_i) begin
         for (int b = 0; b < SW; b++) begin
            if (sel_i[b]) begin
               mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
            end
         end
      end
      if (ack_set && !we_i) begin
         dat_o <= mem[idx];  // Valid during the ack cycle
      end
   end

   // Master must hold the beat until it is acked
   a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
      ack_o |-> (stb_i && cyc_i));

   a_cycle_type: assert property (@(posedge clk_i) disable iff (rst_i)
      cyc_i |-> ((cti_i inside {cti_classic, cti_incr, cti_end}) && (bte_i == 2'b00)));

endmodule

`default_nettype wire

//--- hdl/mam_wb_top.sv
// Top level of the memory access bridge with its Wishbone SRAM.
// Exposes the request, write stream and read stream ports and sets the
// width, depth and wait-state parameters for both blocks.

`timescale 1ns/1ps
`default_nettype none

module mam_wb_top #(
   parameter int DATA_WIDTH  = 32,
   parameter int ADDR_WIDTH  = 32,
   parameter int MEM_WORDS   = 1024,
   parameter int WAIT_STATES = 1
) (
   input  wire                                           clk_i,
   input  wire                                           rst_i,

   input  wire                                           req_valid_i,
   output logic                                          req_ready_o,
   input  wire  mam_wb_pkg::mam_op_t                     req_rw_i,
   input  wire  [ADDR_WIDTH-1:0]                         req_addr_i,
   input  wire                                           req_burst_i,
   input  wire  [mam_wb_pkg::BEATS_W-1:0]                req_beats_i,

   input  wire                                           write_valid_i,
   input  wire  [DATA_WIDTH-1:0]                         write_data_i,
   input  wire  [mam_wb_pkg::sel_width(DATA_WIDTH)-1:0]  write_strb_i,
   output logic                                          write_ready_o,

   output logic                                          read_valid_o,
   output logic [DATA_WIDTH-1:0]                         read_data_o,
   input  wire                                           read_ready_i
);

   import mam_wb_pkg::*;

   localparam int SW = sel_width(DATA_WIDTH);

   logic                  stb;
   logic                  cyc;
   logic                  we;
   logic                  ack;
   logic [ADDR_WIDTH-1:0] addr;
   logic [DATA_WIDTH-1:0] dat_m2s;  // Write data to the SRAM
   logic [DATA_WIDTH-1:0] dat_s2m;  // Read data from the SRAM
   wb_cti_t               cti;
   logic [1:0]            bte;
   logic [SW-1:0]         sel;

   mam_wb_if #(
      .DATA_WIDTH (DATA_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH)
   ) mam_wb_if_i (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .req_valid_i   (req_valid_i),
      .req_ready_o   (req_ready_o),
      .req_rw_i      (req_rw_i),
      .req_addr_i    (req_addr_i),
      .req_burst_i   (req_burst_i),
      .req_beats_i   (req_beats_i),
      .write_valid_i (write_valid_i),
      .write_data_i  (write_data_i),
      .write_strb_i  (write_strb_i),
      .write_ready_o (write_ready_o),
      .read_valid_o  (read_valid_o),
      .read_data_o   (read_data_o),
      .read_ready_i  (read_ready_i),
      .stb_o         (stb),
      .cyc_o         (cyc),
      .we_o          (we),
      .addr_o        (addr),
      .dat_o         (dat_m2s),
      .cti_o         (cti),
      .bte_o         (bte),
      .sel_o         (sel),
      .ack_i         (ack),
      .dat_i         (dat_s2m)
   );

   wb_sram #(
      .DATA_WIDTH  (DATA_WIDTH),
      .ADDR_WIDTH  (ADDR_WIDTH),
      .MEM_WORDS   (MEM_WORDS),
      .WAIT_STATES (WAIT_STATES)
   ) wb_sram_i (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .stb_i  (stb),
      .cyc_i  (cyc),
      .we_i   (we),
      .addr_i (addr),
      .dat_i  (dat_m2s),
      .sel_i  (sel),
      .cti_i  (cti),
      .bte_i  (bte),
      .ack_o  (ack),
      .dat_o  (dat_s2m)
   );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// Clock and reset source for the bridge testbench.
// Free-running clock; reset is held high for a set number of rising edges
// and released shortly after the last one.

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int HALF_PERIOD  = 10,  // ns
   parameter int RESET_CYCLES = 8
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #HALF_PERIOD;
         clk_o = ~clk_o;
      end
   end

   initial begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES) begin
         @(posedge clk_o);
      end
      #2;
      rst_o = 1'b0;  // Released off the edge like other inputs
   end

endmodule

`default_nettype wire

//--- test/mam_wb_tb.sv
// Testbench for the memory access bridge with its Wishbone SRAM.
// Drives requests and write words, predicts read words from a shadow memory
// and compares every delivered word in a separate process. Inputs change 2 ns
// after the rising edge, outputs are sampled on the falling edge.

`timescale 1ns/1ps
`default_nettype none

module mam_wb_tb;

   import mam_wb_pkg::*;

   localparam int DATA_WIDTH  = 32;
   localparam int ADDR_WIDTH  = 32;
   localparam int MEM_WORDS   = 1024;
   localparam int WAIT_STATES = 1;
   localparam int SW          = sel_width(DATA_WIDTH);
   localparam int MARGIN      = 2000;  // Watchdog cycles beyond the beat budget
   localparam int IDLE_LIMIT  = 64;    // Cycles for a request to finish
   localparam int REGION      = 512;   // Prefilled words for mixed traffic

   logic                  clk;
   logic                  rst;
   logic                  req_valid;
   logic                  req_ready;
   mam_op_t               req_rw;
   logic [ADDR_WIDTH-1:0] req_addr;
   logic                  req_burst;
   logic [BEATS_W-1:0]    req_beats;
   logic                  write_valid;
   logic [DATA_WIDTH-1:0] write_data;
   logic [SW-1:0]         write_strb;
   logic                  write_ready;
   logic                  read_valid;
   logic [DATA_WIDTH-1:0] read_data;
   logic                  read_ready;

   logic [31:0]           lfsr_state;
   logic [DATA_WIDTH-1:0] shadow [MEM_WORDS];  // Expected SRAM contents
   logic [DATA_WIDTH-1:0] exp_q [$];           // Read words still to arrive
   int err_count      = 0;
   int check_count    = 0;
   int reads_done     = 0;
   int reads_expected = 0;
   int beats_issued   = 0;
   int tests_passed   = 0;
   int tests_failed   = 0;
   int test_err_start = 0;

   tb_clock #(.HALF_PERIOD(10), .RESET_CYCLES(8)) tb_clock_i (.clk_o(clk), .rst_o(rst));

   mam_wb_top #(
      .DATA_WIDTH  (DATA_WIDTH),
      .ADDR_WIDTH  (ADDR_WIDTH),
      .MEM_WORDS   (MEM_WORDS),
      .WAIT_STATES (WAIT_STATES)
   ) mam_wb_top_i (
      .clk_i         (clk),
      .rst_i         (rst),
      .req_valid_i   (req_valid),
      .req_ready_o   (req_ready),
      .req_rw_i      (req_rw),
      .req_addr_i    (req_addr),
      .req_burst_i   (req_burst),
      .req_beats_i   (req_beats),
      .write_valid_i (write_valid),
      .write_data_i  (write_data),
      .write_strb_i  (write_strb),
      .write_ready_o (write_ready),
      .read_valid_o  (read_valid),
      .read_data_o   (read_data),
      .read_ready_i  (read_ready)
   );

   // Galois LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};  // One step per bit
         lfsr_state = lfsr_step(lfsr_state);
      end
      return v;
   endfunction

   // Byte lanes under the select take the new data, the rest keep the old
   function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
         input logic [DATA_WIDTH-1:0] new_word, input logic [SW-1:0] lanes);
      logic [DATA_WIDTH-1:0] w;
      w = old_word;
      for (int b = 0; b < SW; b++) begin
         if (lanes[b]) begin
            w[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return w;
   endfunction

   task automatic check_word(input logic [DATA_WIDTH-1:0] got, input logic [DATA_WIDTH-1:0] want,
         input string what);
      check_count++;
      if (got !== want) begin
         err_count++;
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
      end
   endtask

   task automatic check_flag(input logic got, input logic want, input string what);
      check_count++;
      if (got !== want) begin
         err_count++;
         $display("** Error at %0t: %s is %b, expected %b", $time, what, got, want);
      end
   endtask

   task automatic wait_idle(input string what);
      int n;
      n = 0;
      @(negedge clk);
      while (!req_ready && n < IDLE_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!req_ready) begin
         err_count++;
         $display("The %s request did not finish within %0d cycles (time %0t)",
                  what, IDLE_LIMIT, $time);
      end
      check_flag(read_valid, 1'b0, {what, " end, read_valid"});
      @(posedge clk);
      #2;
   endtask

   task automatic run_write(input int word_idx, input logic burst, input int beats,
         input logic [SW-1:0] strb, input logic gaps);
      int sent;
      logic take_req;
      logic take_wr;
      logic [SW-1:0] lanes;
      sent  = 0;
      lanes = burst ? {SW{1'b1}} : strb;  // Bursts write every lane
      beats_issued += beats;
      req_valid   = 1'b1;
      req_rw      = op_write;
      req_addr    = ADDR_WIDTH'(word_idx * SW);
      req_burst   = burst;
      req_beats   = BEATS_W'(beats);
      write_data  = DATA_WIDTH'(random_bits(DATA_WIDTH));
      write_strb  = strb;
      write_valid = !gaps || (random_bits(1) == 1);
      while (sent < beats) begin
         @(negedge clk);
         take_req = req_valid && req_ready;
         take_wr  = write_valid && write_ready;
         @(posedge clk);
         #2;
         if (take_req) begin
            req_valid = 1'b0;
         end
         if (take_wr) begin
            shadow[word_idx + sent] = merge_bytes(shadow[word_idx + sent], write_data, lanes);
            sent++;
            write_data = DATA_WIDTH'(random_bits(DATA_WIDTH));
         end
         if (take_wr || !write_valid) begin  // A pending word is held until taken
            write_valid = (sent < beats) && (!gaps || (random_bits(1) == 1));
         end
      end
      write_valid = 1'b0;
      wait_idle("write");
   endtask

   task automatic run_read(input int word_idx, input logic burst, input int beats,
         input logic stall);
      int got;
      logic take_req;
      logic take_rd;
      got = 0;
      beats_issued   += beats;
      reads_expected += beats;
      for (int k = 0; k < beats; k++) begin
         exp_q.push_back(shadow[word_idx + k]);
      end
      req_valid  = 1'b1;
      req_rw     = op_read;
      req_addr   = ADDR_WIDTH'(word_idx * SW);
      req_burst  = burst;
      req_beats  = BEATS_W'(beats);
      read_ready = !stall || (random_bits(1) == 1);
      while (got < beats) begin
         @(negedge clk);
         take_req = req_valid && req_ready;
         take_rd  = read_valid && read_ready;
         @(posedge clk);
         #2;
         if (take_req) begin
            req_valid = 1'b0;
         end
         if (take_rd) begin
            got++;
         end
         read_ready = !stall || (random_bits(1) == 1);
      end
      read_ready = 1'b1;  // Any extra word still reaches the compare process
      wait_idle("read");
   endtask

   task automatic finish_test(input int num, input string name);
      if (err_count == test_err_start) begin
         tests_passed++;
         $display("Test %0d %s: ok", num, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: %0d errors", num, name, err_count - test_err_start);
      end
      test_err_start = err_count;
   endtask

   // Every delivered read word against the oldest prediction
   always @(negedge clk) begin : compare_reads
      logic [DATA_WIDTH-1:0] want;
      if (!rst && read_valid && read_ready) begin
         if (exp_q.size() == 0) begin
            err_count++;
            $display("Read word %h delivered at %0t with no read outstanding", read_data, $time);
         end else begin
            want = exp_q.pop_front();
            check_word(read_data, want, "read word");
         end
         reads_done++;
      end
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles <= 200 * beats_issued + MARGIN) begin
         @(posedge clk);
         cycles++;
      end
      $display("Watchdog expired after %0d cycles, the run hung", cycles);
      $display("Result: FAILED");
      $finish;
   end

   initial begin : stimulus
      int idx;
      int len;
      logic burst;
      logic [SW-1:0] strb;
      lfsr_state  = 32'd91921;
      req_valid   = 1'b0;
      req_rw      = op_read;
      req_addr    = '0;
      req_burst   = 1'b0;
      req_beats   = '0;
      write_valid = 1'b0;
      write_data  = '0;
      write_strb  = '0;
      read_ready  = 1'b0;
      do begin
         @(posedge clk);
      end while (rst !== 1'b0);
      #2;

      @(negedge clk);
      check_flag(req_ready, 1'b1, "req_ready after reset");
      check_flag(write_ready, 1'b0, "write_ready after reset");
      check_flag(read_valid, 1'b0, "read_valid after reset");
      @(posedge clk);
      #2;
      finish_test(1, "reset state");

      idx = int'(random_bits(10));
      run_write(idx, 1'b0, 1, {SW{1'b1}}, 1'b0);
      run_read(idx, 1'b0, 1, 1'b0);
      finish_test(2, "single write and read");

      repeat (4) begin
         idx = int'(random_bits(10));
         run_write(idx, 1'b0, 1, {SW{1'b1}}, 1'b0);  // Known word before merging
         repeat (3) begin
            strb = SW'(random_bits(SW));
            run_write(idx, 1'b0, 1, strb, 1'b1);
         end
         run_read(idx, 1'b0, 1, 1'b0);
      end
      finish_test(3, "partial strobes");

      repeat (3) begin
         len = 2 + int'(random_bits(5));
         idx = int'(random_bits(10)) % (MEM_WORDS - len);
         run_write(idx, 1'b1, len, SW'(random_bits(SW)), 1'b1);
         run_read(idx, 1'b1, len, 1'b0);
      end
      finish_test(4, "burst write with gaps");

      repeat (3) begin
         len = 1 + int'(random_bits(5));  // Includes one-beat bursts
         idx = int'(random_bits(10)) % (MEM_WORDS - len);
         run_write(idx, 1'b1, len, {SW{1'b1}}, 1'b0);
         run_read(idx, 1'b1, len, 1'b1);
      end
      finish_test(5, "burst read with stalls");

      run_write(REGION, 1'b1, 64, {SW{1'b1}}, 1'b0);
      repeat (16) begin
         burst = random_bits(1) == 1;
         len   = burst ? 1 + int'(random_bits(3)) : 1;
         idx   = REGION + int'(random_bits(6)) % (65 - len);
         if (random_bits(1) == 1) begin
            strb = burst ? {SW{1'b1}} : SW'(random_bits(SW));
            run_write(idx, burst, len, strb, random_bits(1) == 1);
         end else begin
            run_read(idx, burst, len, random_bits(1) == 1);
         end
      end
      check_flag(reads_done == reads_expected, 1'b1, "read count matches requests");
      finish_test(6, "mixed back-to-back");

      $display("Tests passed %0d, failed %0d; checks %0d, errors %0d",
               tests_passed, tests_failed, check_count, err_count);
      if (tests_failed == 0 && err_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- mam_wb.f
hdl/mam_wb_pkg.sv
hdl/mam_wb_if.sv
hdl/wb_sram.sv
hdl/mam_wb_top.sv
test/tb_clock.sv
test/mam_wb_tb.sv
